/* sound_mem_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sound memory types: widths, PSRAM request and response, state encodings.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package sound_mem_pkg;

	// byte address as the clients see it.
	typedef logic [23:0] sample_addr_t;
	// halfword address on the PSRAM. top bit selects the chip.
	typedef logic [22:0] half_addr_t;
	typedef logic [31:0] word_data_t;
	typedef logic [15:0] half_data_t;
	typedef logic [7:0]  sample_byte_t;
	typedef logic [1:0]  client_t;
	typedef logic [3:0]  wait_cnt_t;

	// who the current transfer belongs to.
	localparam client_t client_word = 2'd0;
	localparam client_t client_a    = 2'd1;
	localparam client_t client_b    = 2'd2;

	// longest data phase before the controller moves on without cram_wait.
	localparam int unsigned psram_wait_max = 15;

	typedef struct packed {
		half_addr_t addr;
		word_data_t wdata;
		logic       write;
		// even half then odd half.
		logic       wide;
	} psram_req_t;

	typedef struct packed {
		logic       done;
		word_data_t rdata;
	} psram_rsp_t;

	typedef enum logic [1:0] {
		arb_idle,
		arb_read_single,
		arb_write_single
	} arb_state_t;

	typedef enum logic [1:0] {
		bus_idle,
		bus_addr_phase,
		bus_data_phase,
		bus_gap
	} bus_state_t;

endpackage

/* sample_arbiter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fixed priority arbiter for the loader word port and ADPCM channels A and B.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module sample_arbiter import sound_mem_pkg::*; (
	input  logic         clk_8M,
	input  logic         reset_l_main,

	input  logic         word_rd,
	input  logic         word_wr,
	input  sample_addr_t word_addr,
	input  word_data_t   word_data,
	output word_data_t   word_q,
	output logic         word_busy,

	input  sample_addr_t adpcm_a_addr,
	input  logic         adpcm_a_req,
	output sample_byte_t adpcm_a_data,
	output logic         adpcm_a_ack,

	input  sample_addr_t adpcm_b_addr,
	input  logic         adpcm_b_req,
	output sample_byte_t adpcm_b_data,
	output logic         adpcm_b_ack,

	output psram_req_t   mem_req,
	output logic         mem_sel,
	input  psram_rsp_t   mem_rsp
);

	arb_state_t   state;
	client_t      client;
	logic         lane;
	logic         word_req;
	logic         a_pending;
	logic         b_pending;
	logic         take_word;
	logic         take_a;
	logic         take_b;
	logic         finish;
	sample_addr_t chan_addr;
	sample_byte_t lane_byte;

	// a toggle request is open while req and ack differ.
	assign a_pending = adpcm_a_req != adpcm_a_ack;
	assign b_pending = adpcm_b_req != adpcm_b_ack;
	assign word_req  = word_rd || word_wr;

	// word port first, then A, then B.
	assign take_word = (state == arb_idle) && word_req;
	assign take_a    = (state == arb_idle) && !word_req && a_pending;
	assign take_b    = (state == arb_idle) && !word_req && !a_pending && b_pending;
	assign finish    = (state != arb_idle) && mem_rsp.done;

	assign chan_addr = take_a ? adpcm_a_addr : adpcm_b_addr;
	// odd byte address sits in the upper lane.
	assign lane_byte = lane ? mem_rsp.rdata[15:8] : mem_rsp.rdata[7:0];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// control state.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk_8M or negedge reset_l_main) begin
		if (!reset_l_main) begin
			state       <= arb_idle;
			mem_sel     <= 1'b0;
			word_busy   <= 1'b0;
			adpcm_a_ack <= 1'b0;
			adpcm_b_ack <= 1'b0;
		end else begin
			if (take_word) begin
				state     <= word_wr ? arb_write_single : arb_read_single;
				mem_sel   <= 1'b1;
				word_busy <= 1'b1;
			end else if (take_a || take_b) begin
				state     <= arb_read_single;
				mem_sel   <= 1'b1;
				word_busy <= 1'b1;
			end else if (finish) begin
				// done is one cycle wide so select drops right after it.
				state     <= arb_idle;
				mem_sel   <= 1'b0;
				word_busy <= 1'b0;
				if (client == client_a) begin
					adpcm_a_ack <= adpcm_a_req;
				end
				if (client == client_b) begin
					adpcm_b_ack <= adpcm_b_req;
				end
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// request and return data.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk_8M) begin
		if (take_word) begin
			mem_req.addr  <= word_addr[23:1];
			mem_req.wdata <= word_data;
			mem_req.write <= word_wr;
			mem_req.wide  <= 1'b1;
			client        <= client_word;
			lane          <= word_addr[0];
		end else if (take_a || take_b) begin
			// byte fetch is a single half read.
			mem_req.addr  <= chan_addr[23:1];
			mem_req.write <= 1'b0;
			mem_req.wide  <= 1'b0;
			client        <= take_a ? client_a : client_b;
			lane          <= chan_addr[0];
		end

		if (finish && (state == arb_read_single)) begin
			case (client)
				client_a: adpcm_a_data <= lane_byte;
				client_b: adpcm_b_data <= lane_byte;
				default:  word_q       <= mem_rsp.rdata;
			endcase
		end
	end

endmodule

/* psram_bus_ctrl.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PSRAM multiplexed bus sequencer with halfword split and chip select.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module psram_bus_ctrl import sound_mem_pkg::*; (
	input  logic       clk_8M,
	input  logic       reset_l_main,

	input  psram_req_t mem_req,
	input  logic       mem_sel,
	output psram_rsp_t mem_rsp,

	output logic [5:0] cram_a,
	output half_data_t cram_dq_out,
	output logic       cram_dq_oe,
	output logic       cram_adv_n,
	output logic       cram_ce0_n,
	output logic       cram_ce1_n,
	output logic       cram_oe_n,
	output logic       cram_we_n,
	input  half_data_t cram_dq_in,
	input  logic       cram_wait
);

	bus_state_t state;
	logic       odd_half;
	wait_cnt_t  wait_cnt;
	logic       done;
	word_data_t rdata;
	half_addr_t cur_addr;
	half_data_t wr_half;
	logic       chip_on;
	logic       phase_end;
	logic       in_data;

	// second half of a wide access goes to address + 1.
	assign cur_addr  = {mem_req.addr[22:1], mem_req.addr[0] | odd_half};
	assign wr_half   = odd_half ? mem_req.wdata[31:16] : mem_req.wdata[15:0];
	assign chip_on   = (state == bus_addr_phase) || (state == bus_data_phase);
	assign in_data   = state == bus_data_phase;
	assign phase_end = !cram_wait || (wait_cnt == wait_cnt_t'(psram_wait_max));

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// pin decode from the phase.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign cram_a      = cur_addr[21:16];
	assign cram_adv_n  = state != bus_addr_phase;
	assign cram_ce0_n  = !(chip_on && !cur_addr[22]);
	assign cram_ce1_n  = !(chip_on && cur_addr[22]);
	assign cram_oe_n   = !(in_data && !mem_req.write);
	assign cram_we_n   = !(in_data && mem_req.write);
	// low address bits share the data pins.
	assign cram_dq_oe  = (state == bus_addr_phase) || (in_data && mem_req.write);
	assign cram_dq_out = (state == bus_addr_phase) ? cur_addr[15:0] : wr_half;

	assign mem_rsp.done  = done;
	assign mem_rsp.rdata = rdata;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// phase sequencer.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk_8M or negedge reset_l_main) begin
		if (!reset_l_main) begin
			state    <= bus_idle;
			odd_half <= 1'b0;
			wait_cnt <= '0;
			done     <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				bus_idle: begin
					// select is still high during the done cycle.
					if (mem_sel && !done) begin
						state    <= bus_addr_phase;
						odd_half <= 1'b0;
					end
				end
				bus_addr_phase: begin
					state    <= bus_data_phase;
					wait_cnt <= '0;
				end
				bus_data_phase: begin
					if (phase_end) begin
						state <= bus_gap;
					end else begin
						wait_cnt <= wait_cnt + 1'b1;
					end
				end
				bus_gap: begin
					if (mem_req.wide && !odd_half) begin
						odd_half <= 1'b1;
						state    <= bus_addr_phase;
					end else begin
						state <= bus_idle;
						done  <= 1'b1;
					end
				end
				default: state <= bus_idle;
			endcase
		end
	end

	// read capture into the matching half.
	always_ff @(posedge clk_8M) begin
		if (in_data && phase_end && !mem_req.write) begin
			if (odd_half) begin
				rdata[31:16] <= cram_dq_in;
			end else begin
				rdata[15:0] <= cram_dq_in;
			end
		end
	end

endmodule

/* sound_mem_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sound sample memory top: arbiter above the PSRAM bus controller.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module sound_mem_top import sound_mem_pkg::*; (
	input  logic         clk_8M,
	input  logic         reset_l_main,

	input  logic         word_rd,
	input  logic         word_wr,
	input  sample_addr_t word_addr,
	input  word_data_t   word_data,
	output word_data_t   word_q,
	output logic         word_busy,

	input  sample_addr_t adpcm_a_addr,
	input  logic         adpcm_a_req,
	output sample_byte_t adpcm_a_data,
	output logic         adpcm_a_ack,
	input  sample_addr_t adpcm_b_addr,
	input  logic         adpcm_b_req,
	output sample_byte_t adpcm_b_data,
	output logic         adpcm_b_ack,

	output logic [5:0]   cram_a,
	output half_data_t   cram_dq_out,
	output logic         cram_dq_oe,
	output logic         cram_adv_n,
	output logic         cram_ce0_n,
	output logic         cram_ce1_n,
	output logic         cram_oe_n,
	output logic         cram_we_n,
	input  half_data_t   cram_dq_in,
	input  logic         cram_wait
);

	// link between arbiter and bus controller.
	psram_req_t mem_req;
	logic       mem_sel;
	psram_rsp_t mem_rsp;

	sample_arbiter u_arbiter (.*);

	psram_bus_ctrl u_bus_ctrl (.*);

endmodule

/* tb_clock_gen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench clock and reset source.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_clock_gen (
	output logic clk_8M,
	output logic reset_l_main
);

	// period of 10.
	initial begin
		clk_8M = 1'b0;
		forever #5 clk_8M = ~clk_8M;
	end

	// reset held for two cycles.
	initial begin
		reset_l_main = 1'b0;
		repeat (2) @(posedge clk_8M);
		#1;
		reset_l_main = 1'b1;
	end

endmodule

/* psram_model.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// behavioral two chip PSRAM with multiplexed address/data bus and wait.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module psram_model import sound_mem_pkg::*; (
	input  logic       clk_8M,
	input  logic [5:0] cram_a,
	input  half_data_t cram_dq_out,
	input  logic       cram_dq_oe,
	input  logic       cram_adv_n,
	input  logic       cram_ce0_n,
	input  logic       cram_ce1_n,
	input  logic       cram_oe_n,
	input  logic       cram_we_n,
	output half_data_t cram_dq_in,
	output logic       cram_wait
);

	half_data_t  mem0 [0:255];
	half_data_t  mem1 [0:255];
	logic [21:0] addr;
	logic        chip;
	logic [1:0]  wait_cnt;
	half_data_t  rd_data;
	half_data_t  dq_bus;

	assign rd_data = chip ? mem1[addr[7:0]] : mem0[addr[7:0]];

	// controller drive first, then read data. a released bus reads zero.
	assign dq_bus     = cram_dq_oe ? cram_dq_out : (!cram_oe_n ? rd_data : '0);
	assign cram_dq_in = dq_bus;

	// wait stays high for the first three data cycles.
	assign cram_wait = wait_cnt != 2'd3;

	always_ff @(posedge clk_8M) begin
		if (!cram_adv_n && !(cram_ce0_n && cram_ce1_n)) begin
			addr     <= {cram_a, dq_bus};
			chip     <= !cram_ce1_n;
			wait_cnt <= 2'd0;
		end else if (!cram_oe_n || !cram_we_n) begin
			if (wait_cnt != 2'd3) begin
				wait_cnt <= wait_cnt + 2'd1;
			end else if (!cram_we_n) begin
				if (chip) begin
					mem1[addr[7:0]] <= dq_bus;
				end else begin
					mem0[addr[7:0]] <= dq_bus;
				end
			end
		end
	end

endmodule

/* sound_mem_assertions.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PSRAM strobe and chip enable checks, bound into the bus controller.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module sound_mem_assertions (
	input logic clk_8M,
	input logic reset_l_main,
	input logic cram_adv_n,
	input logic cram_ce0_n,
	input logic cram_ce1_n,
	input logic cram_oe_n,
	input logic cram_we_n
);

	oe_we_exclusive: assert property (@(posedge clk_8M) disable iff (!reset_l_main)
		!(!cram_oe_n && !cram_we_n))
		else $error("oe_n and we_n low in the same cycle");

	ce_exclusive: assert property (@(posedge clk_8M) disable iff (!reset_l_main)
		!(!cram_ce0_n && !cram_ce1_n))
		else $error("both chip enables low");

	// address latch only toward a selected chip.
	adv_with_ce: assert property (@(posedge clk_8M) disable iff (!reset_l_main)
		!cram_adv_n |-> (!cram_ce0_n || !cram_ce1_n))
		else $error("adv_n low with no chip enabled");

endmodule

bind psram_bus_ctrl sound_mem_assertions u_assertions (
	.clk_8M       (clk_8M),
	.reset_l_main (reset_l_main),
	.cram_adv_n   (cram_adv_n),
	.cram_ce0_n   (cram_ce0_n),
	.cram_ce1_n   (cram_ce1_n),
	.cram_oe_n    (cram_oe_n),
	.cram_we_n    (cram_we_n)
);

/* sound_mem_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// directed tests for the sound sample memory against a PSRAM model.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module sound_mem_tb import sound_mem_pkg::*; ();

	localparam int test_count  = 5;
	localparam int test_cycles = 200;
	localparam int clk_period  = 10;
	localparam int wait_limit  = 200;

	logic         clk_8M;
	logic         reset_l_main;
	logic         word_rd;
	logic         word_wr;
	sample_addr_t word_addr;
	word_data_t   word_data;
	word_data_t   word_q;
	logic         word_busy;
	sample_addr_t adpcm_a_addr;
	logic         adpcm_a_req;
	sample_byte_t adpcm_a_data;
	logic         adpcm_a_ack;
	sample_addr_t adpcm_b_addr;
	logic         adpcm_b_req;
	sample_byte_t adpcm_b_data;
	logic         adpcm_b_ack;
	logic [5:0]   cram_a;
	half_data_t   cram_dq_out;
	logic         cram_dq_oe;
	logic         cram_adv_n;
	logic         cram_ce0_n;
	logic         cram_ce1_n;
	logic         cram_oe_n;
	logic         cram_we_n;
	half_data_t   cram_dq_in;
	logic         cram_wait;

	logic [31:0]  lfsr_state;
	int           error_count;
	int           test_errors;
	int           tests_run;
	int           tests_failed;

	tb_clock_gen u_clock (
		.clk_8M       (clk_8M),
		.reset_l_main (reset_l_main)
	);

	psram_model u_psram (.*);

	sound_mem_top uut (.*);

	// fibonacci LFSR, taps 32 22 2 1, one step per bit.
	function automatic word_data_t random_word();
		word_data_t w;
		w = '0;
		for (int i = 0; i < 32; i++) begin
			lfsr_state = {lfsr_state[30:0],
				lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
			w = {w[30:0], lfsr_state[0]};
		end
		return w;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
			error_count++;
			test_errors++;
		end
	endtask

	// 0 word port, 1 channel A, 2 channel B.
	function automatic logic reached(input int which);
		case (which)
			0:       return !word_busy;
			1:       return adpcm_a_ack == adpcm_a_req;
			default: return adpcm_b_ack == adpcm_b_req;
		endcase
	endfunction

	task automatic wait_for(input int which);
		int n;
		n = 0;
		while (!reached(which) && n < wait_limit) begin
			@(posedge clk_8M);
			#1;
			n++;
		end
		if (!reached(which)) begin
			$display("transfer on client %0d did not finish in %0d cycles", which, wait_limit);
			error_count++;
			test_errors++;
		end
	endtask

	task automatic word_access(input logic write, input sample_addr_t addr,
			input word_data_t data);
		@(posedge clk_8M);
		#1;
		word_wr   = write;
		word_rd   = !write;
		word_addr = addr;
		word_data = data;
		@(posedge clk_8M);
		#1;
		word_wr = 1'b0;
		word_rd = 1'b0;
		wait_for(0);
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (test_errors != 0) begin
			tests_failed++;
		end
		$display("%s: done, %0d errors", name, test_errors);
		test_errors = 0;
	endtask

	task automatic word_round_trip();
		word_data_t   written [4];
		sample_addr_t addr;
		check_value("word_busy", 0, 32'(word_busy));
		for (int i = 0; i < 4; i++) begin
			written[i] = random_word();
			addr = 24'h000100 + sample_addr_t'(i * 8);
			word_access(1'b1, addr, written[i]);
			// busy stays low once the transfer has ended.
			@(posedge clk_8M);
			#1;
			check_value("word_busy", 0, 32'(word_busy));
		end
		for (int i = 0; i < 4; i++) begin
			addr = 24'h000100 + sample_addr_t'(i * 8);
			word_access(1'b0, addr, '0);
			check_value("word_q", written[i], word_q);
			@(posedge clk_8M);
			#1;
			check_value("word_busy", 0, 32'(word_busy));
		end
		finish_test("word round trip");
	endtask

	task automatic channel_bytes(input logic use_b, input string name);
		word_data_t   w;
		sample_addr_t base;
		logic         ack_before;
		logic         other_before;
		string        sig;
		w = random_word();
		base = use_b ? 24'h000030 : 24'h000020;
		sig = use_b ? "adpcm_b" : "adpcm_a";
		word_access(1'b1, base, w);
		for (int off = 0; off < 4; off++) begin
			@(posedge clk_8M);
			#1;
			ack_before = use_b ? adpcm_b_ack : adpcm_a_ack;
			other_before = use_b ? adpcm_a_ack : adpcm_b_ack;
			adpcm_a_addr = base + sample_addr_t'(off);
			adpcm_b_addr = base + sample_addr_t'(off);
			if (use_b) begin
				adpcm_b_req = !adpcm_b_ack;
			end else begin
				adpcm_a_req = !adpcm_a_ack;
			end
			wait_for(use_b ? 2 : 1);
			// one toggle per request, so the ack holds a cycle later.
			@(posedge clk_8M);
			#1;
			// little endian, offset 0 is the low byte.
			check_value({sig, "_data"}, 32'(w[8 * off +: 8]),
				32'(use_b ? adpcm_b_data : adpcm_a_data));
			check_value({sig, "_ack"}, 32'(!ack_before), 32'(use_b ? adpcm_b_ack : adpcm_a_ack));
			check_value(use_b ? "adpcm_a_ack" : "adpcm_b_ack", 32'(other_before),
				32'(use_b ? adpcm_a_ack : adpcm_b_ack));
		end
		finish_test(name);
	endtask

	// same low bits on both chips.
	task automatic chip_select();
		word_data_t low_w;
		word_data_t high_w;
		low_w = random_word();
		high_w = random_word();
		if (high_w == low_w) begin
			high_w = ~low_w;
		end
		word_access(1'b1, 24'h000080, low_w);
		word_access(1'b1, 24'h800080, high_w);
		word_access(1'b0, 24'h000080, '0);
		check_value("word_q", low_w, word_q);
		word_access(1'b0, 24'h800080, '0);
		check_value("word_q", high_w, word_q);
		finish_test("chip selection");
	endtask

	task automatic priority_order();
		word_data_t lanes_w;
		word_data_t read_w;
		logic       a_before;
		logic       b_before;
		lanes_w = random_word();
		read_w = random_word();
		word_access(1'b1, 24'h000060, lanes_w);
		word_access(1'b1, 24'h000070, read_w);
		@(posedge clk_8M);
		#1;
		a_before = adpcm_a_ack;
		b_before = adpcm_b_ack;
		word_rd = 1'b1;
		word_addr = 24'h000070;
		adpcm_a_addr = 24'h000061;
		adpcm_a_req = !adpcm_a_ack;
		adpcm_b_addr = 24'h000062;
		adpcm_b_req = !adpcm_b_ack;
		@(posedge clk_8M);
		#1;
		word_rd = 1'b0;
		// word first, both channels still open.
		wait_for(0);
		check_value("word_q", read_w, word_q);
		check_value("adpcm_a_ack", 32'(a_before), 32'(adpcm_a_ack));
		check_value("adpcm_b_ack", 32'(b_before), 32'(adpcm_b_ack));
		wait_for(1);
		check_value("adpcm_b_ack", 32'(b_before), 32'(adpcm_b_ack));
		wait_for(2);
		check_value("adpcm_a_data", 32'(lanes_w[15:8]), 32'(adpcm_a_data));
		check_value("adpcm_b_data", 32'(lanes_w[23:16]), 32'(adpcm_b_data));
		check_value("adpcm_a_ack", 32'(!a_before), 32'(adpcm_a_ack));
		check_value("adpcm_b_ack", 32'(!b_before), 32'(adpcm_b_ack));
		finish_test("priority and simultaneity");
	endtask

	initial begin
		word_rd = 1'b0;
		word_wr = 1'b0;
		word_addr = '0;
		word_data = '0;
		adpcm_a_addr = '0;
		adpcm_a_req = 1'b0;
		adpcm_b_addr = '0;
		adpcm_b_req = 1'b0;
		lfsr_state = 32'hf049;
		error_count = 0;
		test_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		wait (reset_l_main);
		word_round_trip();
		channel_bytes(1'b0, "channel A bytes");
		channel_bytes(1'b1, "channel B bytes");
		chip_select();
		priority_order();
		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
			error_count);
		if (error_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	// five tests of at most 200 cycles each.
	initial begin
		#(test_count * test_cycles * clk_period);
		$display("run timed out after %0d time units", test_count * test_cycles * clk_period);
		$display("Some tests failed");
		$finish;
	end

endmodule

/* compile.f */
sound_mem_pkg.sv
sample_arbiter.sv
psram_bus_ctrl.sv
sound_mem_top.sv
tb_clock_gen.sv
psram_model.sv
sound_mem_assertions.sv
sound_mem_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= sound_mem_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS    := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Some tests failed" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "All tests passed" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
